// ==== common/cpu_pkg.sv ====
package cpu_pkg;

    // Single-byte 6502 opcodes handled by the core
    typedef enum logic [7:0] {
        ASL_A = 8'h0A,
        ROL_A = 8'h2A,
        LSR_A = 8'h4A,
        ROR_A = 8'h6A,
        INX   = 8'hE8,
        INY   = 8'hC8,
        DEX   = 8'hCA,
        DEY   = 8'h88,
        TAX   = 8'hAA,
        TAY   = 8'hA8,
        TSX   = 8'hBA,
        TXA   = 8'h8A,
        TXS   = 8'h9A,
        TYA   = 8'h98,
        SEC   = 8'h38,
        SED   = 8'hF8,
        SEI   = 8'h78,
        CLC   = 8'h18,
        CLD   = 8'hD8,
        CLI   = 8'h58,
        CLV   = 8'hB8,
        NOP   = 8'hEA
    } opcode_t;

    typedef enum logic [1:0] {IDLE, T0, T1} tstate_t;

    // Internal bus drivers
    typedef enum logic [2:0] {BUS_ACC, BUS_X, BUS_Y, BUS_SP, BUS_ALU, BUS_HOST} bus_src_t;

    typedef enum logic {ALU_ADD, ALU_SHR} alu_op_t;
    typedef enum logic {A_BUS, A_ZERO} a_in_t;
    typedef enum logic {B_BUS, B_ONES} b_in_t;
    typedef enum logic [1:0] {CIN_ZERO, CIN_ONE, CIN_PSR} cin_t;

    typedef enum logic [2:0] {DST_NONE, DST_ACC, DST_X, DST_Y, DST_SP} dest_t;

    typedef enum logic [3:0] {
        FLG_NONE, FLG_NZ, FLG_NZC,
        FLG_SET_C, FLG_CLR_C,
        FLG_SET_D, FLG_CLR_D,
        FLG_SET_I, FLG_CLR_I,
        FLG_CLR_V
    } flag_op_t;

    // APB register map
    localparam logic [2:0] ADDR_OPCODE = 3'd0;
    localparam logic [2:0] ADDR_A      = 3'd1;
    localparam logic [2:0] ADDR_X      = 3'd2;
    localparam logic [2:0] ADDR_Y      = 3'd3;
    localparam logic [2:0] ADDR_SP     = 3'd4;
    localparam logic [2:0] ADDR_PSR    = 3'd5;
    localparam logic [2:0] ADDR_PCL    = 3'd6;
    localparam logic [2:0] ADDR_PCH    = 3'd7;

    // Slots of the register read vector
    localparam int RD_A  = 0;
    localparam int RD_X  = 1;
    localparam int RD_Y  = 2;
    localparam int RD_SP = 3;

    // PSR layout
    localparam int PSR_C = 0;
    localparam int PSR_Z = 1;
    localparam int PSR_I = 2;
    localparam int PSR_D = 3;
    localparam int PSR_B = 4;
    localparam int PSR_U = 5;
    localparam int PSR_V = 6;
    localparam int PSR_N = 7;

    localparam logic [7:0] PSR_RESET = 8'h34;

endpackage

// ==== common/micro_if.sv ====
`timescale 1ns/1ps

interface micro_if
    import cpu_pkg::*;
();

    // Control word from the sequencer
    bus_src_t       bus_src;
    a_in_t          a_in;
    b_in_t          b_in;
    cin_t           cin;
    alu_op_t        alu_op;
    logic           load_alu;
    dest_t          dest;
    flag_op_t       flag_op;
    logic           pc_inc;
    logic [7:0]     host_data;

    // Datapath values
    logic [7:0]       bus_value;
    logic [3:0][7:0]  reg_rd;
    logic [15:0]      pc;
    logic [7:0]       alu_result;
    logic             alu_carry;
    logic [7:0]       psr;

    modport ctrl (
        output bus_src, a_in, b_in, cin, alu_op, load_alu, dest, flag_op, pc_inc,
        output host_data,
        input  reg_rd, pc, psr
    );

    modport regs (
        input  bus_src, dest, pc_inc, host_data, alu_result,
        output bus_value, reg_rd, pc
    );

    modport alu (
        input  bus_value, a_in, b_in, cin, alu_op, load_alu, psr,
        output alu_result, alu_carry
    );

    modport status (
        input  flag_op, bus_value, alu_carry,
        output psr
    );

endinterface

// ==== exec/micro_sequencer.sv ====
`timescale 1ns/1ps

module micro_sequencer
    import cpu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [2:0]  paddr,
    input  logic [7:0]  pwdata,
    output logic [7:0]  prdata,
    output logic        pready,
    output logic        pslverr,
    micro_if.ctrl       mif
);

    tstate_t   state;
    tstate_t   state_next;
    opcode_t   op;
    logic      legal;
    logic      op_wr;
    logic      access;
    bus_src_t  src_sel;
    dest_t     t0_dest;
    flag_op_t  t0_flag;
    dest_t     wb_dest;
    flag_op_t  wb_flag;

    // The opcode is the APB write data, held stable for the whole transfer
    assign op        = opcode_t'(pwdata);
    assign op_wr     = psel && pwrite && (paddr == ADDR_OPCODE);
    assign access    = psel && penable;
    assign mif.host_data = pwdata;

    // Legal opcodes take one wait state, finishing in T1
    assign pready  = access && (!op_wr || !legal || state == T1);
    assign pslverr = access && op_wr && !legal;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            IDLE:    state_next = (psel && !penable && op_wr && legal) ? T0 : IDLE;
            T0:      state_next = T1;
            default: state_next = IDLE;
        endcase
    end

    // Per-opcode control table
    always_comb begin
        legal      = 1'b1;
        src_sel    = BUS_ACC;
        t0_dest    = DST_NONE;
        t0_flag    = FLG_NONE;
        wb_dest    = DST_NONE;
        wb_flag    = FLG_NZ;
        mif.a_in   = A_BUS;
        mif.b_in   = B_BUS;
        mif.cin    = CIN_ZERO;
        mif.alu_op = ALU_ADD;
        case (op)
            ASL_A, ROL_A, LSR_A, ROR_A: begin
                // Left shifts are A + A, right shifts use the shifter
                wb_dest    = DST_ACC;
                wb_flag    = FLG_NZC;
                mif.alu_op = (op == LSR_A || op == ROR_A) ? ALU_SHR : ALU_ADD;
                mif.cin    = (op == ROL_A || op == ROR_A) ? CIN_PSR : CIN_ZERO;
            end
            INX, INY: begin
                src_sel  = (op == INX) ? BUS_X : BUS_Y;
                wb_dest  = (op == INX) ? DST_X : DST_Y;
                mif.a_in = A_ZERO;
                mif.cin  = CIN_ONE;
            end
            DEX, DEY: begin
                src_sel  = (op == DEX) ? BUS_X : BUS_Y;
                wb_dest  = (op == DEX) ? DST_X : DST_Y;
                mif.b_in = B_ONES;
            end
            TAX:     begin src_sel = BUS_ACC; t0_dest = DST_X;   t0_flag = FLG_NZ; end
            TAY:     begin src_sel = BUS_ACC; t0_dest = DST_Y;   t0_flag = FLG_NZ; end
            TSX:     begin src_sel = BUS_SP;  t0_dest = DST_X;   t0_flag = FLG_NZ; end
            TXA:     begin src_sel = BUS_X;   t0_dest = DST_ACC; t0_flag = FLG_NZ; end
            TYA:     begin src_sel = BUS_Y;   t0_dest = DST_ACC; t0_flag = FLG_NZ; end
            TXS:     begin src_sel = BUS_X;   t0_dest = DST_SP;  end
            SEC:     t0_flag = FLG_SET_C;
            CLC:     t0_flag = FLG_CLR_C;
            SED:     t0_flag = FLG_SET_D;
            CLD:     t0_flag = FLG_CLR_D;
            SEI:     t0_flag = FLG_SET_I;
            CLI:     t0_flag = FLG_CLR_I;
            CLV:     t0_flag = FLG_CLR_V;
            NOP:     ;
            default: legal = 1'b0;
        endcase
    end

    // Control word for the current T-state or host register write
    always_comb begin
        mif.bus_src  = src_sel;
        mif.load_alu = 1'b0;
        mif.dest     = DST_NONE;
        mif.flag_op  = FLG_NONE;
        mif.pc_inc   = 1'b0;
        if (state == T0) begin
            mif.dest     = t0_dest;
            mif.flag_op  = t0_flag;
            mif.load_alu = (wb_dest != DST_NONE);
        end else if (state == T1) begin
            mif.pc_inc = 1'b1;
            if (wb_dest != DST_NONE) begin
                mif.bus_src = BUS_ALU;
                mif.dest    = wb_dest;
                mif.flag_op = wb_flag;
            end
        end else if (access && pwrite) begin
            mif.bus_src = BUS_HOST;
            case (paddr)
                ADDR_A:  mif.dest = DST_ACC;
                ADDR_X:  mif.dest = DST_X;
                ADDR_Y:  mif.dest = DST_Y;
                ADDR_SP: mif.dest = DST_SP;
                default: mif.dest = DST_NONE;
            endcase
        end
    end

    // Read data mux, opcode address reads as zero
    always_comb begin
        case (paddr)
            ADDR_A:   prdata = mif.reg_rd[RD_A];
            ADDR_X:   prdata = mif.reg_rd[RD_X];
            ADDR_Y:   prdata = mif.reg_rd[RD_Y];
            ADDR_SP:  prdata = mif.reg_rd[RD_SP];
            ADDR_PSR: prdata = mif.psr;
            ADDR_PCL: prdata = mif.pc[7:0];
            ADDR_PCH: prdata = mif.pc[15:8];
            default:  prdata = 8'h00;
        endcase
    end

    a_pready_in_access: assert property (@(posedge clk) disable iff (reset)
        pready |-> (psel && penable));

    // An instruction always finishes in the access cycle after T0
    a_t1_completes: assert property (@(posedge clk) disable iff (reset)
        (state == T0) |=> (state == T1 && pready && !pslverr));

endmodule

// ==== exec/alu_shifter.sv ====
`timescale 1ns/1ps

module alu_shifter
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    micro_if.alu  mif
);

    logic [7:0]  a_val;
    logic [7:0]  b_val;
    logic        c_val;
    logic [8:0]  sum;
    logic [7:0]  shr_val;

    // Operand selection
    assign a_val = (mif.a_in == A_ZERO) ? 8'h00 : mif.bus_value;
    assign b_val = (mif.b_in == B_ONES) ? 8'hFF : mif.bus_value;

    always_comb begin
        case (mif.cin)
            CIN_ONE: c_val = 1'b1;
            CIN_PSR: c_val = mif.psr[PSR_C];
            default: c_val = 1'b0;
        endcase
    end

    assign sum = {1'b0, a_val} + {1'b0, b_val} + {8'h00, c_val};

    // Carry in enters at bit 7, bit 0 leaves as carry
    assign shr_val = {c_val, a_val[7:1]};

    // Hold register, read back in T1
    always_ff @(posedge clk) begin
        if (reset) begin
            mif.alu_result <= 8'h00;
            mif.alu_carry  <= 1'b0;
        end else if (mif.load_alu) begin
            if (mif.alu_op == ALU_SHR) begin
                mif.alu_result <= shr_val;
                mif.alu_carry  <= a_val[0];
            end else begin
                mif.alu_result <= sum[7:0];
                mif.alu_carry  <= sum[8];
            end
        end
    end

endmodule

// ==== exec/register_file.sv ====
`timescale 1ns/1ps

module register_file
    import cpu_pkg::*;
#(
    parameter logic [15:0] RESET_PC = 16'h0200
) (
    input  logic   clk,
    input  logic   reset,
    micro_if.regs  mif
);

    logic [7:0]   acc;
    logic [7:0]   x_reg;
    logic [7:0]   y_reg;
    logic [7:0]   sp;
    logic [15:0]  pc;
    logic         self_load;

    // Internal bus source mux
    always_comb begin
        case (mif.bus_src)
            BUS_ACC:  mif.bus_value = acc;
            BUS_X:    mif.bus_value = x_reg;
            BUS_Y:    mif.bus_value = y_reg;
            BUS_SP:   mif.bus_value = sp;
            BUS_ALU:  mif.bus_value = mif.alu_result;
            default:  mif.bus_value = mif.host_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc   <= 8'h00;
            x_reg <= 8'h00;
            y_reg <= 8'h00;
            sp    <= 8'hFF;
            pc    <= RESET_PC;
        end else begin
            case (mif.dest)
                DST_ACC: acc   <= mif.bus_value;
                DST_X:   x_reg <= mif.bus_value;
                DST_Y:   y_reg <= mif.bus_value;
                DST_SP:  sp    <= mif.bus_value;
                default: ;
            endcase
            if (mif.pc_inc) begin
                pc <= pc + 16'd1;
            end
        end
    end

    assign mif.reg_rd[RD_A]  = acc;
    assign mif.reg_rd[RD_X]  = x_reg;
    assign mif.reg_rd[RD_Y]  = y_reg;
    assign mif.reg_rd[RD_SP] = sp;
    assign mif.pc            = pc;

    // A register never loads from itself
    assign self_load = (mif.dest == DST_ACC && mif.bus_src == BUS_ACC)
                    || (mif.dest == DST_X   && mif.bus_src == BUS_X)
                    || (mif.dest == DST_Y   && mif.bus_src == BUS_Y)
                    || (mif.dest == DST_SP  && mif.bus_src == BUS_SP);

    a_no_self_load: assert property (@(posedge clk) disable iff (reset) !self_load);

endmodule

// ==== exec/status_register.sv ====
`timescale 1ns/1ps

module status_register
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    micro_if.status  mif
);

    logic flag_c;
    logic flag_z;
    logic flag_i;
    logic flag_d;
    logic flag_v;
    logic flag_n;

    always_ff @(posedge clk) begin
        if (reset) begin
            flag_c <= PSR_RESET[PSR_C];
            flag_z <= PSR_RESET[PSR_Z];
            flag_i <= PSR_RESET[PSR_I];
            flag_d <= PSR_RESET[PSR_D];
            flag_v <= PSR_RESET[PSR_V];
            flag_n <= PSR_RESET[PSR_N];
        end else begin
            case (mif.flag_op)
                FLG_NZ, FLG_NZC: begin
                    flag_n <= mif.bus_value[7];
                    flag_z <= (mif.bus_value == 8'h00);
                    if (mif.flag_op == FLG_NZC) begin
                        flag_c <= mif.alu_carry;
                    end
                end
                FLG_SET_C: flag_c <= 1'b1;
                FLG_CLR_C: flag_c <= 1'b0;
                FLG_SET_D: flag_d <= 1'b1;
                FLG_CLR_D: flag_d <= 1'b0;
                FLG_SET_I: flag_i <= 1'b1;
                FLG_CLR_I: flag_i <= 1'b0;
                FLG_CLR_V: flag_v <= 1'b0;
                default:   ;
            endcase
        end
    end

    // U and B read as one
    assign mif.psr = {flag_n, flag_v, 1'b1, 1'b1, flag_d, flag_i, flag_z, flag_c};

    a_psr_u_set: assert property (@(posedge clk) disable iff (reset) mif.psr[PSR_U]);

endmodule

// ==== src/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
    parameter logic [15:0] RESET_PC = 16'h0200
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [2:0]  paddr,
    input  logic [7:0]  pwdata,
    output logic [7:0]  prdata,
    output logic        pready,
    output logic        pslverr
);

    micro_if u_mif ();

    // APB completer, decode and T-state control
    micro_sequencer u_seq (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .mif     (u_mif.ctrl)
    );

    alu_shifter u_alu (
        .clk   (clk),
        .reset (reset),
        .mif   (u_mif.alu)
    );

    register_file #(
        .RESET_PC (RESET_PC)
    ) u_regs (
        .clk   (clk),
        .reset (reset),
        .mif   (u_mif.regs)
    );

    status_register u_psr (
        .clk   (clk),
        .reset (reset),
        .mif   (u_mif.status)
    );

endmodule

// ==== verification/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Architectural state as seen over APB
typedef struct packed {
    logic [7:0]   a;
    logic [7:0]   x;
    logic [7:0]   y;
    logic [7:0]   sp;
    logic [7:0]   psr;
    logic [15:0]  pc;
} cpu_state_t;

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic ref_legal(input logic [7:0] op);
    case (op)
        ASL_A, ROL_A, LSR_A, ROR_A, INX, INY, DEX, DEY,
        TAX, TAY, TSX, TXA, TXS, TYA,
        SEC, SED, SEI, CLC, CLD, CLI, CLV, NOP: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

// Next state after one instruction, 6502 rules
function automatic cpu_state_t ref_execute(input cpu_state_t s, input logic [7:0] op);
    cpu_state_t  n;
    logic [7:0]  res;
    logic        nz;
    n   = s;
    res = 8'h00;
    nz  = 1'b1;
    if (!ref_legal(op)) begin
        return s;
    end
    case (op)
        ASL_A:   {n.psr[PSR_C], n.a} = {s.a, 1'b0};
        ROL_A:   {n.psr[PSR_C], n.a} = {s.a, s.psr[PSR_C]};
        LSR_A:   {n.a, n.psr[PSR_C]} = {1'b0, s.a};
        ROR_A:   {n.a, n.psr[PSR_C]} = {s.psr[PSR_C], s.a};
        INX:     n.x = s.x + 8'd1;
        INY:     n.y = s.y + 8'd1;
        DEX:     n.x = s.x - 8'd1;
        DEY:     n.y = s.y - 8'd1;
        TAX:     n.x = s.a;
        TAY:     n.y = s.a;
        TSX:     n.x = s.sp;
        TXA:     n.a = s.x;
        TYA:     n.a = s.y;
        TXS:     n.sp = s.x;
        SEC:     n.psr[PSR_C] = 1'b1;
        CLC:     n.psr[PSR_C] = 1'b0;
        SED:     n.psr[PSR_D] = 1'b1;
        CLD:     n.psr[PSR_D] = 1'b0;
        SEI:     n.psr[PSR_I] = 1'b1;
        CLI:     n.psr[PSR_I] = 1'b0;
        CLV:     n.psr[PSR_V] = 1'b0;
        default: ;
    endcase
    // N and Z follow the register that was written, TXS leaves them alone
    case (op)
        ASL_A, ROL_A, LSR_A, ROR_A, TXA, TYA: res = n.a;
        INX, DEX, TAX, TSX:                    res = n.x;
        INY, DEY, TAY:                         res = n.y;
        default:                               nz = 1'b0;
    endcase
    if (nz) begin
        n.psr[PSR_N] = res[7];
        n.psr[PSR_Z] = (res == 8'h00);
    end
    n.pc = s.pc + 16'd1;
    return n;
endfunction

`endif

// ==== verification/tb_cpu_top.sv ====
`timescale 1ns/1ps

module tb_cpu_top
    import cpu_pkg::*;
();

`include "tb_ref_model.svh"

    localparam logic [15:0] RESET_PC    = 16'h0200;
    localparam logic [31:0] LFSR_SEED   = 32'ha943d96e;
    localparam int          MAX_WAIT    = 8;
    // Tests take roughly 8k cycles
    localparam int          CYCLE_LIMIT = 20000;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [2:0]  paddr;
    logic [7:0]  pwdata;
    logic [7:0]  prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] lfsr_state = LFSR_SEED;
    cpu_state_t  model;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          tests = 0;
    int          test_errors = 0;
    int          wait_states = 0;

    cpu_top #(.RESET_PC(RESET_PC)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // One LFSR step per random bit
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        r = 8'h00;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[6:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic compare(input string what, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns: %s read %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    // Setup cycle, then access cycles until pready, sampled at the falling edge
    task automatic apb_transfer(input logic wr, input logic [2:0] addr, input logic [7:0] wdata,
                                output logic [7:0] rdata, output logic err);
        int waits;
        waits = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready && waits < MAX_WAIT) begin
            @(negedge clk);
            waits++;
        end
        wait_states = waits;
        if (!pready) begin
            errors++;
            $display("ERROR at %0t ns: pready never came for address %0d", $time, addr);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_reg(input logic [2:0] addr, input logic [7:0] value);
        logic [7:0] rd;
        logic       err;
        apb_transfer(1'b1, addr, value, rd, err);
        compare("pslverr on register write", {7'h00, err}, 8'h00);
        compare("wait states on register write", 8'(wait_states), 8'd0);
        case (addr)
            ADDR_A:  model.a  = value;
            ADDR_X:  model.x  = value;
            ADDR_Y:  model.y  = value;
            default: model.sp = value;
        endcase
    endtask

    task automatic exec_op(input logic [7:0] op);
        logic [7:0] rd;
        logic       err;
        apb_transfer(1'b1, ADDR_OPCODE, op, rd, err);
        compare($sformatf("pslverr for opcode %02h", op), {7'h00, err}, {7'h00, !ref_legal(op)});
        // Legal opcodes finish in T1, one wait state; illegal ones finish at once
        compare($sformatf("wait states for opcode %02h", op), 8'(wait_states),
                ref_legal(op) ? 8'd1 : 8'd0);
        model = ref_execute(model, op);
    endtask

    task automatic check_state(input string tag);
        cpu_state_t got;
        logic [6:0] rd_err;
        apb_transfer(1'b0, ADDR_A, 8'h00, got.a, rd_err[0]);
        apb_transfer(1'b0, ADDR_X, 8'h00, got.x, rd_err[1]);
        apb_transfer(1'b0, ADDR_Y, 8'h00, got.y, rd_err[2]);
        apb_transfer(1'b0, ADDR_SP, 8'h00, got.sp, rd_err[3]);
        apb_transfer(1'b0, ADDR_PSR, 8'h00, got.psr, rd_err[4]);
        apb_transfer(1'b0, ADDR_PCL, 8'h00, got.pc[7:0], rd_err[5]);
        apb_transfer(1'b0, ADDR_PCH, 8'h00, got.pc[15:8], rd_err[6]);
        compare({tag, " read pslverr"}, {1'b0, rd_err}, 8'h00);
        compare({tag, " A"}, got.a, model.a);
        compare({tag, " X"}, got.x, model.x);
        compare({tag, " Y"}, got.y, model.y);
        compare({tag, " SP"}, got.sp, model.sp);
        compare({tag, " PSR"}, got.psr, model.psr);
        compare({tag, " PCL"}, got.pc[7:0], model.pc[7:0]);
        compare({tag, " PCH"}, got.pc[15:8], model.pc[15:8]);
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("Test %0d %s: %0d errors", tests, name, errors - test_errors);
        test_errors = errors;
    endtask

    initial begin
        logic [7:0] xfer_ops [6];
        logic [7:0] step_ops [4];
        logic [7:0] step_vals [6];
        logic [7:0] shift_ops [4];
        logic [7:0] flag_ops [8];
        logic [7:0] value;
        logic [2:0] pick;
        int         found;
        xfer_ops  = '{TAX, TAY, TXA, TYA, TSX, TXS};
        step_ops  = '{INX, INY, DEX, DEY};
        step_vals = '{8'h00, 8'hFF, 8'h7F, 8'h80, 8'h01, 8'hFE};
        shift_ops = '{ASL_A, LSR_A, ROL_A, ROR_A};
        flag_ops  = '{SEC, CLC, SED, CLD, SEI, CLI, CLV, NOP};
        reset   <= 1'b1;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= 3'd0;
        pwdata  <= 8'h00;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        model = '{a: 8'h00, x: 8'h00, y: 8'h00, sp: 8'hFF, psr: 8'h34, pc: RESET_PC};
        check_state("reset");
        for (int i = 0; i < 16; i++) begin
            write_reg(ADDR_A, rand_bits(8));
            write_reg(ADDR_X, rand_bits(8));
            write_reg(ADDR_Y, rand_bits(8));
            write_reg(ADDR_SP, rand_bits(8));
            check_state("readback");
        end
        finish_test("reset and register access");

        for (int i = 0; i < 12; i++) begin
            foreach (xfer_ops[j]) begin
                // First pass preloads zeros for the Z flag
                write_reg(ADDR_A, (i == 0) ? 8'h00 : rand_bits(8));
                write_reg(ADDR_X, (i == 0) ? 8'h00 : rand_bits(8));
                write_reg(ADDR_Y, (i == 0) ? 8'h00 : rand_bits(8));
                write_reg(ADDR_SP, (i == 0) ? 8'h00 : rand_bits(8));
                exec_op(xfer_ops[j]);
                check_state("transfer");
            end
        end
        finish_test("transfers");

        for (int i = 0; i < 12; i++) begin
            value = (i < 6) ? step_vals[i] : rand_bits(8);
            foreach (step_ops[j]) begin
                write_reg(ADDR_X, value);
                write_reg(ADDR_Y, value);
                exec_op(step_ops[j]);
                check_state("inc/dec");
            end
        end
        finish_test("increment and decrement");

        for (int i = 0; i < 16; i++) begin
            foreach (shift_ops[j]) begin
                write_reg(ADDR_A, rand_bits(8));
                exec_op((rand_bits(1) != 8'h00) ? SEC : CLC);
                exec_op(shift_ops[j]);
                check_state("shift");
            end
        end
        finish_test("shifts and rotates");

        for (int i = 0; i < 32; i++) begin
            pick = 3'(rand_bits(3));
            exec_op(flag_ops[pick]);
            check_state("flag");
        end
        finish_test("flag instructions");

        found = 0;
        for (int i = 0; i < 64 && found < 16; i++) begin
            value = rand_bits(8);
            if (!ref_legal(value)) begin
                exec_op(value);
                check_state("illegal");
                found++;
            end
        end
        finish_test("illegal opcodes");

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+verification
common/cpu_pkg.sv
common/micro_if.sv
exec/micro_sequencer.sv
exec/alu_shifter.sv
exec/register_file.sv
exec/status_register.sv
src/cpu_top.sv
verification/tb_cpu_top.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_cpu_top
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
